/* hdl/pinmux_consts.svh */
//--------------------------------------------------------------------------
// Register bus and pad constants of the pin multiplexer
// Word offsets are word indices, so the byte address is offset times four
// Block numbers must stay in step with reg_blk_e in pinmux_pkg
//--------------------------------------------------------------------------
`ifndef PINMUX_CONSTS_SVH
`define PINMUX_CONSTS_SVH

// Register bus widths
`define REG_AW      11
`define REG_DW      32
`define REG_BEW     4

// Block select field of the address
`define BLK_SEL_MSB 10
`define BLK_SEL_LSB 7

// Pad count
`define PAD_NUM     16

// Global block words, indexed by addr[6:2]
`define GLBL_CHIP_ID    5'd0
`define GLBL_MULTI_FUNC 5'd1
`define GLBL_IRQ_MASK   5'd2
`define GLBL_IRQ_STAT   5'd3
`define GLBL_SOFT_IRQ   5'd4

// GPIO block words, indexed by addr[5:2]
`define GPIO_DIR      4'd0
`define GPIO_OUT      4'd1
`define GPIO_IN       4'd2
`define GPIO_POS_EN   4'd3
`define GPIO_NEG_EN   4'd4
`define GPIO_IRQ_STAT 4'd5
`define GPIO_IRQ_MASK 4'd6

// Read-only identifier, "PIN1" in ASCII
`define CHIP_ID_VAL 32'h5049_4E31

// UART pad positions
`define UART_TX_PAD 0
`define UART_RX_PAD 1

`endif

/* hdl/pinmux_pkg.sv */
//--------------------------------------------------------------------------
// Bus structs, block and pad-function enums of the pin multiplexer
// Block enum values are the numbers in address bits 10 to 7
//--------------------------------------------------------------------------
`default_nettype none

`include "pinmux_consts.svh"

package pinmux_pkg;

   // Host request, held stable until ack
   typedef struct packed {
      logic                 cs;
      logic                 wr;
      logic [`REG_AW-1:0]   addr;
      logic [`REG_DW-1:0]   wdata;
      logic [`REG_BEW-1:0]  be;
   } reg_req_t;

   // Block response, rdata valid while ack is high
   typedef struct packed {
      logic [`REG_DW-1:0]   rdata;
      logic                 ack;
   } reg_rsp_t;

   // Register blocks behind the decoder, other numbers unmapped
   typedef enum logic [3:0] {
      BLK_GLBL = 4'd0,
      BLK_GPIO = 4'd1
   } reg_blk_e;

   // Pad owner
   typedef enum logic {
      FUNC_GPIO = 1'b0,
      FUNC_UART = 1'b1
   } pad_func_e;

   // Byte enables widened to a bit mask
   function automatic logic [`REG_DW-1:0] be_mask(input logic [`REG_BEW-1:0] be);
      logic [`REG_DW-1:0] mask;
      for (int i = 0; i < `REG_BEW; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

/* hdl/reg_blk_decode.sv */
//--------------------------------------------------------------------------
// Register bus decoder, one request in flight at a time
// Response mux is combinational, so no cycle is added to a block's ack
// Unmapped block numbers get a one-cycle ack with zero data
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module reg_blk_decode
   import pinmux_pkg::*;
(
   input  logic     mclk,
   input  logic     s_reset_ssn,
   input  reg_req_t req_i,
   output reg_rsp_t rsp_o,
   output reg_req_t glbl_req_o,
   output reg_req_t gpio_req_o,
   input  reg_rsp_t glbl_rsp_i,
   input  reg_rsp_t gpio_rsp_i
);

   reg_blk_e req_blk;        // block field of the live request
   reg_blk_e blk_sel;        // block captured while cs is high
   logic     blk_unmapped;
   logic     unmap_ack;

   assign req_blk      = reg_blk_e'(req_i.addr[`BLK_SEL_MSB:`BLK_SEL_LSB]);
   assign blk_unmapped = (req_blk != BLK_GLBL) && (req_blk != BLK_GPIO);

   // Same request to both blocks, cs only to the addressed one
   always_comb begin
      glbl_req_o    = req_i;
      gpio_req_o    = req_i;
      glbl_req_o.cs = req_i.cs & (req_blk == BLK_GLBL);
      gpio_req_o.cs = req_i.cs & (req_blk == BLK_GPIO);
   end

   //-----------------------------------------------------------------------
   // Block capture and local ack for holes in the map
   //-----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         blk_sel   <= BLK_GLBL;
         unmap_ack <= 1'b0;
      end else begin
         if (req_i.cs)
            blk_sel <= req_blk;
         // Single pulse, cs still high in the ack cycle
         unmap_ack <= req_i.cs & blk_unmapped & ~unmap_ack;
      end
   end

   // Steer back the captured block
   always_comb begin
      case (blk_sel)
         BLK_GLBL: rsp_o = glbl_rsp_i;
         BLK_GPIO: rsp_o = gpio_rsp_i;
         default:  rsp_o = '{rdata: '0, ack: unmap_ack};
      endcase
   end

   // Any ack seen by the host answers a request from the cycle before
   a_ack_after_req: assert property (
      @(posedge mclk) disable iff (!s_reset_ssn)
      rsp_o.ack |-> $past(req_i.cs)
   );

endmodule

`default_nettype wire

/* hdl/glbl_reg.sv */
//--------------------------------------------------------------------------
// Global registers: chip id, multi-function select and interrupt control
// IRQ_STAT bit 0 is software, bit 1 the GPIO level; only two mask bits
// SOFT_IRQ is a write-only trigger and reads as zero
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module glbl_reg
   import pinmux_pkg::*;
(
   input  logic                mclk,
   input  logic                s_reset_ssn,
   input  reg_req_t            req_i,
   output reg_rsp_t            rsp_o,
   input  logic                gpio_intr_i,
   output logic [`PAD_NUM-1:0] multi_func_o,
   output logic                irq_o
);

   logic [4:0]          word;
   logic                ack_q;
   logic [`REG_DW-1:0]  rdata_q;
   logic                wr_en;
   logic                rd_en;
   logic [`REG_DW-1:0]  wmask;
   logic [`REG_DW-1:0]  wbits;     // written ones, for set and clear words
   logic [`REG_DW-1:0]  rd_word;
   logic [`REG_DW-1:0]  wr_merge;

   logic [`PAD_NUM-1:0] multi_func;
   logic [1:0]          irq_mask;
   logic                soft_irq;
   logic [1:0]          irq_stat;

   assign word  = req_i.addr[6:2];
   // Access happens once, at the edge that raises ack
   assign wr_en = req_i.cs & req_i.wr & ~ack_q;
   assign rd_en = req_i.cs & ~req_i.wr & ~ack_q;
   assign wmask = be_mask(req_i.be);
   assign wbits = req_i.wdata & wmask;

   // Status: software source and live GPIO level
   assign irq_stat = {gpio_intr_i, soft_irq};
   assign irq_o    = |(irq_stat & irq_mask);

   assign multi_func_o = multi_func;

   //-----------------------------------------------------------------------
   // Read mux, also the base for byte-enable merges
   //-----------------------------------------------------------------------
   always_comb begin
      rd_word = '0;
      case (word)
         `GLBL_CHIP_ID:    rd_word = `CHIP_ID_VAL;
         `GLBL_MULTI_FUNC: rd_word[`PAD_NUM-1:0] = multi_func;
         `GLBL_IRQ_MASK:   rd_word[1:0] = irq_mask;
         `GLBL_IRQ_STAT:   rd_word[1:0] = irq_stat;
         default:          rd_word = '0;
      endcase
   end

   assign wr_merge = (rd_word & ~wmask) | wbits;

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q      <= 1'b0;
         multi_func <= '0;
         irq_mask   <= '0;
         soft_irq   <= 1'b0;
      end else begin
         ack_q <= req_i.cs & ~ack_q;
         if (wr_en) begin
            case (word)
               `GLBL_MULTI_FUNC: multi_func <= wr_merge[`PAD_NUM-1:0];
               `GLBL_IRQ_MASK:   irq_mask   <= wr_merge[1:0];
               // Write one to clear the software bit
               `GLBL_IRQ_STAT: begin
                  if (wbits[0])
                     soft_irq <= 1'b0;
               end
               `GLBL_SOFT_IRQ: begin
                  if (wbits[0])
                     soft_irq <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // Read data held for the ack cycle
   always_ff @(posedge mclk) begin
      if (rd_en)
         rdata_q <= rd_word;
   end

   assign rsp_o = '{rdata: rdata_q, ack: ack_q};

   // Held cs must not stretch ack past one cycle
   a_ack_one_cycle: assert property (
      @(posedge mclk) disable iff (!s_reset_ssn)
      rsp_o.ack |=> !rsp_o.ack
   );

endmodule

`default_nettype wire

/* hdl/gpio_ctrl.sv */
//--------------------------------------------------------------------------
// GPIO registers, input synchronizer and edge interrupts
// Pad change is seen in GPIO_IN after 2 cycles, in status after 3
// Status is write-one-to-clear; a new edge wins over a clear
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module gpio_ctrl
   import pinmux_pkg::*;
(
   input  logic                mclk,
   input  logic                s_reset_ssn,
   input  reg_req_t            req_i,
   output reg_rsp_t            rsp_o,
   input  logic [`PAD_NUM-1:0] pad_gpio_in_i,
   output logic [`PAD_NUM-1:0] gpio_dir_o,
   output logic [`PAD_NUM-1:0] gpio_out_o,
   output logic                gpio_intr_o
);

   logic [3:0]          word;
   logic                ack_q;
   logic [`REG_DW-1:0]  rdata_q;
   logic                wr_en;
   logic                rd_en;
   logic [`REG_DW-1:0]  wmask;
   logic [`REG_DW-1:0]  rd_word;
   logic [`REG_DW-1:0]  wr_merge;

   // Config registers, 1 = output in dir
   logic [`PAD_NUM-1:0] dir;
   logic [`PAD_NUM-1:0] out;
   logic [`PAD_NUM-1:0] pos_en;
   logic [`PAD_NUM-1:0] neg_en;
   logic [`PAD_NUM-1:0] irq_stat;
   logic [`PAD_NUM-1:0] irq_mask;

   // Input path
   logic [`PAD_NUM-1:0] in_meta;
   logic [`PAD_NUM-1:0] in_sync;
   logic [`PAD_NUM-1:0] in_prev;
   logic [`PAD_NUM-1:0] edge_set;
   logic [`PAD_NUM-1:0] stat_clr;

   assign word  = req_i.addr[5:2];
   assign wr_en = req_i.cs & req_i.wr & ~ack_q;
   assign rd_en = req_i.cs & ~req_i.wr & ~ack_q;
   assign wmask = be_mask(req_i.be);

   //-----------------------------------------------------------------------
   // Edge detect on the synchronized value
   //-----------------------------------------------------------------------
   assign edge_set = (in_sync & ~in_prev & pos_en) | (~in_sync & in_prev & neg_en);
   assign stat_clr = (wr_en && word == `GPIO_IRQ_STAT) ?
                     (req_i.wdata[`PAD_NUM-1:0] & wmask[`PAD_NUM-1:0]) : '0;

   assign gpio_intr_o = |(irq_stat & irq_mask);
   assign gpio_dir_o  = dir;
   assign gpio_out_o  = out;

   // Read mux, zero above the pad bits
   always_comb begin
      rd_word = '0;
      case (word)
         `GPIO_DIR:      rd_word[`PAD_NUM-1:0] = dir;
         `GPIO_OUT:      rd_word[`PAD_NUM-1:0] = out;
         `GPIO_IN:       rd_word[`PAD_NUM-1:0] = in_sync;
         `GPIO_POS_EN:   rd_word[`PAD_NUM-1:0] = pos_en;
         `GPIO_NEG_EN:   rd_word[`PAD_NUM-1:0] = neg_en;
         `GPIO_IRQ_STAT: rd_word[`PAD_NUM-1:0] = irq_stat;
         `GPIO_IRQ_MASK: rd_word[`PAD_NUM-1:0] = irq_mask;
         default:        rd_word = '0;
      endcase
   end

   assign wr_merge = (rd_word & ~wmask) | (req_i.wdata & wmask);

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q    <= 1'b0;
         dir      <= '0;
         out      <= '0;
         pos_en   <= '0;
         neg_en   <= '0;
         irq_stat <= '0;
         irq_mask <= '0;
         in_meta  <= '0;
         in_sync  <= '0;
         in_prev  <= '0;
      end else begin
         ack_q <= req_i.cs & ~ack_q;
         // Two-flop sync, then one more stage for edges
         in_meta  <= pad_gpio_in_i;
         in_sync  <= in_meta;
         in_prev  <= in_sync;
         irq_stat <= (irq_stat & ~stat_clr) | edge_set;
         if (wr_en) begin
            case (word)
               `GPIO_DIR:      dir      <= wr_merge[`PAD_NUM-1:0];
               `GPIO_OUT:      out      <= wr_merge[`PAD_NUM-1:0];
               `GPIO_POS_EN:   pos_en   <= wr_merge[`PAD_NUM-1:0];
               `GPIO_NEG_EN:   neg_en   <= wr_merge[`PAD_NUM-1:0];
               `GPIO_IRQ_MASK: irq_mask <= wr_merge[`PAD_NUM-1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge mclk) begin
      if (rd_en)
         rdata_q <= rd_word;
   end

   assign rsp_o = '{rdata: rdata_q, ack: ack_q};

   // No ack without the block's own cs one cycle earlier
   a_ack_follows_cs: assert property (
      @(posedge mclk) disable iff (!s_reset_ssn)
      rsp_o.ack |-> $past(req_i.cs)
   );

endmodule

`default_nettype wire

/* hdl/pad_mux.sv */
//--------------------------------------------------------------------------
// Pad routing between GPIO and UART, purely combinational
// Only multi-function bit 0 is honoured; it moves pads 0 and 1 to UART
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module pad_mux
   import pinmux_pkg::*;
(
   input  logic [`PAD_NUM-1:0] gpio_dir_i,
   input  logic [`PAD_NUM-1:0] gpio_out_i,
   input  logic [`PAD_NUM-1:0] multi_func_i,
   input  logic                uart_txd_i,
   input  logic [`PAD_NUM-1:0] pad_in_i,
   output logic [`PAD_NUM-1:0] pad_out_o,
   output logic [`PAD_NUM-1:0] pad_oen_o,
   output logic [`PAD_NUM-1:0] pad_gpio_in_o,
   output logic                uart_rxd_o
);

   pad_func_e pad_func [`PAD_NUM];

   // Owner of each pad
   always_comb begin
      for (int i = 0; i < `PAD_NUM; i++) begin
         if (i == `UART_TX_PAD || i == `UART_RX_PAD)
            pad_func[i] = pad_func_e'(multi_func_i[0]);
         else
            pad_func[i] = FUNC_GPIO;
      end
   end

   //-----------------------------------------------------------------------
   // Output and enable, oen low drives the pad
   //-----------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < `PAD_NUM; i++) begin
         pad_out_o[i] = gpio_out_i[i];
         pad_oen_o[i] = ~gpio_dir_i[i];
      end
      if (pad_func[`UART_TX_PAD] == FUNC_UART) begin
         pad_out_o[`UART_TX_PAD] = uart_txd_i;
         pad_oen_o[`UART_TX_PAD] = 1'b0;
      end
      // Receive pad is input only
      if (pad_func[`UART_RX_PAD] == FUNC_UART) begin
         pad_out_o[`UART_RX_PAD] = 1'b0;
         pad_oen_o[`UART_RX_PAD] = 1'b1;
      end
   end

   // Idle high line when UART is not on the pads
   assign uart_rxd_o = (pad_func[`UART_RX_PAD] == FUNC_UART) ? pad_in_i[`UART_RX_PAD] : 1'b1;

   assign pad_gpio_in_o = pad_in_i;

endmodule

`default_nettype wire

/* hdl/pinmux_top.sv */
//--------------------------------------------------------------------------
// Pin multiplexer top: register decoder, global and GPIO blocks, pad mux
// Host keeps one request in flight; ack comes in the request's 2nd cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module pinmux_top
   import pinmux_pkg::*;
(
   input  logic                mclk,
   input  logic                s_reset_ssn,
   input  reg_req_t            reg_req_i,
   output reg_rsp_t            reg_rsp_o,
   input  logic [`PAD_NUM-1:0] pad_in_i,
   output logic [`PAD_NUM-1:0] pad_out_o,
   output logic [`PAD_NUM-1:0] pad_oen_o,
   input  logic                uart_txd_i,
   output logic                uart_rxd_o,
   output logic                irq_o
);

   reg_req_t            glbl_req;
   reg_req_t            gpio_req;
   reg_rsp_t            glbl_rsp;
   reg_rsp_t            gpio_rsp;
   logic [`PAD_NUM-1:0] multi_func;
   logic [`PAD_NUM-1:0] gpio_dir;
   logic [`PAD_NUM-1:0] gpio_out;
   logic [`PAD_NUM-1:0] pad_gpio_in;
   logic                gpio_intr;

   // Bus decode
   reg_blk_decode u_reg_blk_decode (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .req_i       (reg_req_i),
      .rsp_o       (reg_rsp_o),
      .glbl_req_o  (glbl_req),
      .gpio_req_o  (gpio_req),
      .glbl_rsp_i  (glbl_rsp),
      .gpio_rsp_i  (gpio_rsp)
   );

   glbl_reg u_glbl_reg (
      .mclk         (mclk),
      .s_reset_ssn  (s_reset_ssn),
      .req_i        (glbl_req),
      .rsp_o        (glbl_rsp),
      .gpio_intr_i  (gpio_intr),
      .multi_func_o (multi_func),
      .irq_o        (irq_o)
   );

   gpio_ctrl u_gpio_ctrl (
      .mclk          (mclk),
      .s_reset_ssn   (s_reset_ssn),
      .req_i         (gpio_req),
      .rsp_o         (gpio_rsp),
      .pad_gpio_in_i (pad_gpio_in),
      .gpio_dir_o    (gpio_dir),
      .gpio_out_o    (gpio_out),
      .gpio_intr_o   (gpio_intr)
   );

   // Pad side
   pad_mux u_pad_mux (
      .gpio_dir_i    (gpio_dir),
      .gpio_out_i    (gpio_out),
      .multi_func_i  (multi_func),
      .uart_txd_i    (uart_txd_i),
      .pad_in_i      (pad_in_i),
      .pad_out_o     (pad_out_o),
      .pad_oen_o     (pad_oen_o),
      .pad_gpio_in_o (pad_gpio_in),
      .uart_rxd_o    (uart_rxd_o)
   );

endmodule

`default_nettype wire

/* verification/pinmux_tb.sv */
//--------------------------------------------------------------------------
// Testbench for the pin multiplexer, random stimulus from a fixed seed
// Shadow model of all registers; pad changes settle for 6 cycles
// Bus accesses are one at a time and expect ack in the second cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pinmux_consts.svh"

module pinmux_tb
   import pinmux_pkg::*;
();

   localparam int ACK_TIMEOUT = 20;

   logic                mclk;
   logic                s_reset_ssn;
   reg_req_t            reg_req;
   reg_rsp_t            reg_rsp;
   logic [`PAD_NUM-1:0] pad_in;
   logic [`PAD_NUM-1:0] pad_out;
   logic [`PAD_NUM-1:0] pad_oen;
   logic                uart_txd;
   logic                uart_rxd;
   logic                irq;

   // Shadow registers
   logic [`PAD_NUM-1:0] m_mf;
   logic [1:0]          m_gmask;
   logic                m_soft;
   logic [`PAD_NUM-1:0] m_dir;
   logic [`PAD_NUM-1:0] m_out;
   logic [`PAD_NUM-1:0] m_pos;
   logic [`PAD_NUM-1:0] m_neg;
   logic [`PAD_NUM-1:0] m_stat;
   logic [`PAD_NUM-1:0] m_mask;
   logic [`PAD_NUM-1:0] m_pads;

   int n_checks;
   int n_errors;
   int base_checks;
   int base_errors;

   pinmux_top u_pinmux_top (
      .mclk        (mclk),
      .s_reset_ssn (s_reset_ssn),
      .reg_req_i   (reg_req),
      .reg_rsp_o   (reg_rsp),
      .pad_in_i    (pad_in),
      .pad_out_o   (pad_out),
      .pad_oen_o   (pad_oen),
      .uart_txd_i  (uart_txd),
      .uart_rxd_o  (uart_rxd),
      .irq_o       (irq)
   );

   initial begin
      mclk = 1'b0;
      forever #2 mclk = ~mclk;
   end

   //-----------------------------------------------------------------------
   // Reference model
   //-----------------------------------------------------------------------
   function automatic logic [31:0] lane_mask(input logic [3:0] be);
      logic [31:0] m;
      for (int i = 0; i < 4; i++) begin
         m[8*i +: 8] = be[i] ? 8'hFF : 8'h00;
      end
      return m;
   endfunction

   function automatic logic irq_level();
      logic gpio_lvl;
      gpio_lvl = |(m_stat & m_mask);
      return |({gpio_lvl, m_soft} & m_gmask);
   endfunction

   // Expected read data of any word
   function automatic logic [31:0] expected_word(input logic [3:0] blk, input logic [4:0] word);
      logic [31:0] v;
      v = '0;
      if (blk == BLK_GLBL) begin
         case (word)
            `GLBL_CHIP_ID:    v = `CHIP_ID_VAL;
            `GLBL_MULTI_FUNC: v[15:0] = m_mf;
            `GLBL_IRQ_MASK:   v[1:0] = m_gmask;
            `GLBL_IRQ_STAT:   v[1:0] = {|(m_stat & m_mask), m_soft};
            default:          v = '0;
         endcase
      end else if (blk == BLK_GPIO) begin
         case (word[3:0])
            `GPIO_DIR:      v[15:0] = m_dir;
            `GPIO_OUT:      v[15:0] = m_out;
            `GPIO_IN:       v[15:0] = m_pads;
            `GPIO_POS_EN:   v[15:0] = m_pos;
            `GPIO_NEG_EN:   v[15:0] = m_neg;
            `GPIO_IRQ_STAT: v[15:0] = m_stat;
            `GPIO_IRQ_MASK: v[15:0] = m_mask;
            default:        v = '0;
         endcase
      end
      return v;
   endfunction

   // Byte-enable merge for plain words, set and clear for the others
   function automatic void update_shadow(input logic [3:0] blk, input logic [4:0] word,
                                         input logic [31:0] wdata, input logic [3:0] be);
      logic [31:0] m;
      logic [31:0] nv;
      m  = lane_mask(be);
      nv = (expected_word(blk, word) & ~m) | (wdata & m);
      if (blk == BLK_GLBL) begin
         case (word)
            `GLBL_MULTI_FUNC: m_mf = nv[15:0];
            `GLBL_IRQ_MASK:   m_gmask = nv[1:0];
            `GLBL_IRQ_STAT:   if (wdata[0] & m[0]) m_soft = 1'b0;
            `GLBL_SOFT_IRQ:   if (wdata[0] & m[0]) m_soft = 1'b1;
            default: ;
         endcase
      end else if (blk == BLK_GPIO) begin
         case (word[3:0])
            `GPIO_DIR:      m_dir = nv[15:0];
            `GPIO_OUT:      m_out = nv[15:0];
            `GPIO_POS_EN:   m_pos = nv[15:0];
            `GPIO_NEG_EN:   m_neg = nv[15:0];
            `GPIO_IRQ_MASK: m_mask = nv[15:0];
            `GPIO_IRQ_STAT: m_stat = m_stat & ~(wdata[15:0] & m[15:0]);
            default: ;
         endcase
      end
   endfunction

   //-----------------------------------------------------------------------
   // Checks, bus access and pad stimulus
   //-----------------------------------------------------------------------
   task automatic expect_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("ERR %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic access_reg(input logic [3:0] blk, input logic [4:0] word, input logic wr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata);
      reg_req_t req;
      int       waited;
      req.cs    = 1'b1;
      req.wr    = wr;
      req.addr  = {blk, word, 2'b00};
      req.wdata = wdata;
      req.be    = be;
      @(posedge mclk);
      reg_req <= req;
      waited = 0;
      @(negedge mclk);
      while (!reg_rsp.ack && waited < ACK_TIMEOUT) begin
         @(negedge mclk);
         waited++;
      end
      if (!reg_rsp.ack) begin
         $display("Timeout: no ack within %0d cycles at address 0x%03h", ACK_TIMEOUT, req.addr);
         $display("Finished with errors");
         $finish;
      end
      // Ack belongs in the second cycle of the request
      expect_value("ack latency", 32'(waited), 32'd1);
      rdata = reg_rsp.rdata;
      @(posedge mclk);
      reg_req <= '0;
   endtask

   task automatic write_word(input logic [3:0] blk, input logic [4:0] word,
                             input logic [31:0] data, input logic [3:0] be);
      logic [31:0] unused;
      access_reg(blk, word, 1'b1, data, be, unused);
      update_shadow(blk, word, data, be);
   endtask

   task automatic read_word(input logic [3:0] blk, input logic [4:0] word,
                            output logic [31:0] data);
      access_reg(blk, word, 1'b0, '0, 4'hF, data);
   endtask

   // Drive pads, let them pass the synchronizer, then apply the edge rules
   task automatic apply_pads(input logic [`PAD_NUM-1:0] v);
      @(posedge mclk);
      pad_in <= v;
      repeat (6) @(posedge mclk);
      @(negedge mclk);
      m_stat = m_stat | (v & ~m_pads & m_pos) | (~v & m_pads & m_neg);
      m_pads = v;
   endtask

   task automatic check_irq();
      @(negedge mclk);
      expect_value("irq_o", 32'(irq), 32'(irq_level()));
   endtask

   task automatic end_test(input int num, input string name);
      $display("Test %0d %s: %0d checks, %0d errors", num, name,
               n_checks - base_checks, n_errors - base_errors);
      base_checks = n_checks;
      base_errors = n_errors;
   endtask

   //-----------------------------------------------------------------------
   // Test sequence
   //-----------------------------------------------------------------------
   initial begin
      logic [31:0]         rd;
      logic [3:0]          blk;
      logic [4:0]          word;
      logic                txd;
      int                  idx;
      logic [`PAD_NUM-1:0] exp_oen;
      void'($urandom(93960));
      s_reset_ssn = 1'b0;
      reg_req     = '0;
      pad_in      = '0;
      uart_txd    = 1'b1;
      {m_mf, m_gmask, m_soft, m_dir, m_out} = '0;
      {m_pos, m_neg, m_stat, m_mask, m_pads} = '0;
      {n_checks, n_errors, base_checks, base_errors} = '0;
      repeat (10) @(posedge mclk);
      s_reset_ssn <= 1'b1;

      // Identifier and holes in the block map
      read_word(BLK_GLBL, `GLBL_CHIP_ID, rd);
      expect_value("CHIP_ID", rd, `CHIP_ID_VAL);
      for (int i = 0; i < 4; i++) begin
         blk = 4'(2 + ($urandom() % 14));
         read_word(blk, 5'($urandom()), rd);
         expect_value("unmapped block", rd, 32'd0);
      end
      end_test(1, "chip id and unmapped");

      for (int i = 0; i < 24; i++) begin
         idx = int'($urandom() % 7);
         case (idx)
            0: begin blk = BLK_GLBL; word = `GLBL_MULTI_FUNC; end
            1: begin blk = BLK_GLBL; word = `GLBL_IRQ_MASK; end
            2: begin blk = BLK_GPIO; word = {1'b0, `GPIO_DIR}; end
            3: begin blk = BLK_GPIO; word = {1'b0, `GPIO_OUT}; end
            4: begin blk = BLK_GPIO; word = {1'b0, `GPIO_POS_EN}; end
            5: begin blk = BLK_GPIO; word = {1'b0, `GPIO_NEG_EN}; end
            default: begin blk = BLK_GPIO; word = {1'b0, `GPIO_IRQ_MASK}; end
         endcase
         write_word(blk, word, $urandom(), 4'($urandom()));
         read_word(blk, word, rd);
         expect_value($sformatf("block %0d word %0d", blk, word), rd, expected_word(blk, word));
      end
      check_irq();
      end_test(2, "register write and read back");

      // GPIO pads with UART off
      write_word(BLK_GLBL, `GLBL_MULTI_FUNC, 32'd0, 4'hF);
      for (int i = 0; i < 8; i++) begin
         write_word(BLK_GPIO, {1'b0, `GPIO_DIR}, $urandom(), 4'hF);
         write_word(BLK_GPIO, {1'b0, `GPIO_OUT}, $urandom(), 4'hF);
         @(negedge mclk);
         exp_oen = ~m_dir;
         expect_value("pad_oen_o", 32'(pad_oen), 32'(exp_oen));
         expect_value("pad_out_o", 32'(pad_out), 32'(m_out));
      end
      end_test(3, "gpio pad output");

      // Only the GPIO source reaches irq_o here
      write_word(BLK_GPIO, {1'b0, `GPIO_POS_EN}, $urandom(), 4'hF);
      write_word(BLK_GPIO, {1'b0, `GPIO_NEG_EN}, $urandom(), 4'hF);
      write_word(BLK_GPIO, {1'b0, `GPIO_IRQ_MASK}, $urandom(), 4'hF);
      write_word(BLK_GLBL, `GLBL_IRQ_MASK, 32'h2, 4'hF);
      for (int i = 0; i < 10; i++) begin
         apply_pads(16'($urandom()));
         read_word(BLK_GPIO, {1'b0, `GPIO_IN}, rd);
         expect_value("GPIO_IN", rd, 32'(m_pads));
         read_word(BLK_GPIO, {1'b0, `GPIO_IRQ_STAT}, rd);
         expect_value("GPIO_IRQ_STAT after edges", rd, 32'(m_stat));
         check_irq();
         write_word(BLK_GPIO, {1'b0, `GPIO_IRQ_STAT}, $urandom(), 4'hF);
         read_word(BLK_GPIO, {1'b0, `GPIO_IRQ_STAT}, rd);
         expect_value("GPIO_IRQ_STAT after clear", rd, 32'(m_stat));
         check_irq();
      end
      end_test(4, "gpio input and edge interrupts");

      // Software interrupt, masked first
      write_word(BLK_GLBL, `GLBL_IRQ_MASK, 32'h0, 4'hF);
      write_word(BLK_GLBL, `GLBL_SOFT_IRQ, 32'h1, 4'h1);
      check_irq();
      write_word(BLK_GLBL, `GLBL_IRQ_MASK, 32'h1, 4'hF);
      check_irq();
      read_word(BLK_GLBL, `GLBL_IRQ_STAT, rd);
      expect_value("IRQ_STAT with soft set", rd, expected_word(BLK_GLBL, `GLBL_IRQ_STAT));
      write_word(BLK_GLBL, `GLBL_IRQ_STAT, 32'h1, 4'hF);
      check_irq();
      read_word(BLK_GLBL, `GLBL_IRQ_STAT, rd);
      expect_value("IRQ_STAT after clear", rd, expected_word(BLK_GLBL, `GLBL_IRQ_STAT));
      end_test(5, "software interrupt");

      // UART on pads 0 and 1
      write_word(BLK_GLBL, `GLBL_MULTI_FUNC, 32'h1, 4'hF);
      for (int i = 0; i < 8; i++) begin
         txd = 1'($urandom());
         @(posedge mclk);
         uart_txd <= txd;
         apply_pads(16'($urandom()));
         expect_value("pad 0 out", 32'(pad_out[`UART_TX_PAD]), 32'(txd));
         expect_value("pad 0 oen", 32'(pad_oen[`UART_TX_PAD]), 32'd0);
         expect_value("pad 1 oen", 32'(pad_oen[`UART_RX_PAD]), 32'd1);
         expect_value("uart_rxd_o", 32'(uart_rxd), 32'(m_pads[`UART_RX_PAD]));
      end
      write_word(BLK_GLBL, `GLBL_MULTI_FUNC, 32'h0, 4'hF);
      @(negedge mclk);
      exp_oen = ~m_dir;
      expect_value("uart_rxd_o idle", 32'(uart_rxd), 32'd1);
      expect_value("pad 0 oen back to gpio", 32'(pad_oen[`UART_TX_PAD]),
                   32'(exp_oen[`UART_TX_PAD]));
      end_test(6, "uart pads");

      $display("Total: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/pinmux_pkg.sv
hdl/reg_blk_decode.sv
hdl/glbl_reg.sv
hdl/gpio_ctrl.sv
hdl/pad_mux.sv
hdl/pinmux_top.sv
verification/pinmux_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the pin multiplexer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module pinmux_tb -o pinmux_sim \
   || { echo "Build failed"; exit 1; }

out=$(./obj_dir/pinmux_sim)
echo "$out"

echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
